// File: verilog/lc3b_pkg.sv
package lc3b_pkg;

    localparam int WORD_W = 16;
    localparam int REG_W  = 3;
    localparam int APB_AW = 4;

    // APB register offsets
    localparam logic [APB_AW-1:0] REG_CTRL     = 4'h0;
    localparam logic [APB_AW-1:0] REG_START_PC = 4'h4;
    localparam logic [APB_AW-1:0] REG_STATUS   = 4'h8;
    localparam logic [APB_AW-1:0] REG_RETIRED  = 4'hC;

    // Forwarding mux selects for the EX operands
    localparam logic [1:0] FWD_NONE = 2'b00;
    localparam logic [1:0] FWD_WB   = 2'b01;
    localparam logic [1:0] FWD_MEM  = 2'b10;

    typedef logic [WORD_W-1:0] lc3b_word;
    typedef logic [REG_W-1:0]  lc3b_reg;
    typedef logic [2:0]        lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_and  = 4'b0101,
        op_not  = 4'b1001,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not
    } lc3b_aluop;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  alu_op;
        logic       use_imm;
        logic       mem_read;
        logic       mem_write;
        logic       load_regfile;
        logic       load_cc;
        logic       is_branch;
        logic       is_halt;
    } ctrl_word_t;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word instr;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t cw;
        lc3b_reg    dest;
        lc3b_reg    src1;
        lc3b_reg    src2;
        lc3b_word   src1_val;
        lc3b_word   src2_val;
        lc3b_word   imm5;
        lc3b_word   offset6;
        lc3b_word   pc;
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t cw;
        lc3b_reg    dest;
        lc3b_word   alu_result;
        lc3b_word   store_data;
    } ex_mem_t;

    typedef struct packed {
        ctrl_word_t cw;
        lc3b_reg    dest;
        lc3b_word   wb_value;
    } mem_wb_t;

    typedef struct packed {
        logic     read;
        logic     write;
        lc3b_word addr;
        lc3b_word wdata;
    } mem_req_t;

    typedef struct packed {
        logic     resp;
        lc3b_word rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        lc3b_word          pwdata;
    } apb_req_t;

    typedef struct packed {
        lc3b_word prdata;
        logic     pready;
        logic     pslverr;
    } apb_rsp_t;

endpackage : lc3b_pkg

// File: verilog/cpu_ctrl_regs.sv
`timescale 1ns/1ps

module cpu_ctrl_regs
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  lc3b_pkg::apb_req_t  i_apb,
    input  logic                i_halt_seen,
    input  logic                i_retire,
    output lc3b_pkg::apb_rsp_t  o_apb,
    output logic                o_run,
    output lc3b_pkg::lc3b_word  o_start_pc,
    output logic                o_launch
);

    logic               access;
    logic               wr_ctrl;
    logic               mapped;
    logic               halted;
    lc3b_pkg::lc3b_word retired;
    lc3b_pkg::lc3b_word rdata;

    // Enable phase of an APB transfer, no wait states
    assign access  = i_apb.psel && i_apb.penable;
    assign wr_ctrl = access && i_apb.pwrite && (i_apb.paddr == lc3b_pkg::REG_CTRL);
    assign mapped  = i_apb.paddr inside {lc3b_pkg::REG_CTRL, lc3b_pkg::REG_START_PC,
                                         lc3b_pkg::REG_STATUS, lc3b_pkg::REG_RETIRED};

    // Launch only on a 0 -> 1 edge of run
    assign o_launch = wr_ctrl && i_apb.pwdata[0] && !o_run;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_run      <= 1'b0;
            o_start_pc <= '0;
            halted     <= 1'b0;
            retired    <= '0;
        end else begin
            if (wr_ctrl) begin
                o_run <= i_apb.pwdata[0];
            end else if (i_halt_seen) begin
                o_run <= 1'b0;
            end
            if (access && i_apb.pwrite && (i_apb.paddr == lc3b_pkg::REG_START_PC)) begin
                o_start_pc <= i_apb.pwdata;
            end
            if (o_launch) begin
                halted  <= 1'b0;
                retired <= '0;
            end else begin
                if (i_halt_seen) halted <= 1'b1;
                // Count wraps silently
                if (i_retire) retired <= retired + 16'd1;
            end
        end
    end

    always_comb begin
        case (i_apb.paddr)
            lc3b_pkg::REG_CTRL:     rdata = {15'd0, o_run};
            lc3b_pkg::REG_START_PC: rdata = o_start_pc;
            // Bit 1 run, bit 0 halted
            lc3b_pkg::REG_STATUS:   rdata = {14'd0, o_run, halted};
            lc3b_pkg::REG_RETIRED:  rdata = retired;
            default:                rdata = '0;
        endcase
    end

    assign o_apb.prdata  = rdata;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = access && !mapped;

endmodule : cpu_ctrl_regs

// File: verilog/cpu_control.sv
`timescale 1ns/1ps

module cpu_control
(
    input  lc3b_pkg::lc3b_word   i_instr,
    output lc3b_pkg::ctrl_word_t o_cw
);

    always_comb begin
        // Unknown opcodes fall through as a no-op
        o_cw        = '0;
        o_cw.opcode = lc3b_pkg::lc3b_opcode'(i_instr[15:12]);
        o_cw.alu_op = lc3b_pkg::alu_add;
        case (i_instr[15:12])
            lc3b_pkg::op_add: begin
                o_cw.use_imm      = i_instr[5];
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            lc3b_pkg::op_and: begin
                o_cw.alu_op       = lc3b_pkg::alu_and;
                o_cw.use_imm      = i_instr[5];
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            lc3b_pkg::op_not: begin
                o_cw.alu_op       = lc3b_pkg::alu_not;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            lc3b_pkg::op_ldr: begin
                o_cw.mem_read     = 1'b1;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            lc3b_pkg::op_str: begin
                o_cw.mem_write = 1'b1;
            end
            lc3b_pkg::op_br: begin
                o_cw.is_branch = 1'b1;
            end
            // TRAP only serves as HALT here
            lc3b_pkg::op_trap: begin
                o_cw.is_halt = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule : cpu_control

// File: verilog/regfile.sv
`timescale 1ns/1ps

module regfile
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_we,
    input  lc3b_pkg::lc3b_reg  i_dest,
    input  lc3b_pkg::lc3b_reg  i_src_a,
    input  lc3b_pkg::lc3b_reg  i_src_b,
    input  lc3b_pkg::lc3b_word i_wdata,
    output lc3b_pkg::lc3b_word o_rdata_a,
    output lc3b_pkg::lc3b_word o_rdata_b
);

    lc3b_pkg::lc3b_word regs [2**lc3b_pkg::REG_W];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
        end else if (i_we) begin
            regs[i_dest] <= i_wdata;
        end
    end

    // Write-through so ID sees the value WB writes this cycle
    assign o_rdata_a = (i_we && i_dest == i_src_a) ? i_wdata : regs[i_src_a];
    assign o_rdata_b = (i_we && i_dest == i_src_b) ? i_wdata : regs[i_src_b];

endmodule : regfile

// File: verilog/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage
#(
    parameter type T = logic
)
(
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_hold,
    input  logic i_bubble,
    input  logic i_valid,
    input  T     i_data,
    output logic o_valid,
    output T     o_data
);

    // Hold wins over bubble, bubble wins over load
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (!i_hold) begin
            o_valid <= i_valid && !i_bubble;
        end
    end

    // Payload is meaningless while o_valid is low
    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_data <= i_data;
        end
    end

endmodule : pipe_stage

// File: verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
(
    input  lc3b_pkg::lc3b_reg  i_id_src1,
    input  lc3b_pkg::lc3b_reg  i_id_src2,
    input  logic               i_id_is_branch,
    input  lc3b_pkg::id_ex_t   i_ex,
    input  logic               i_ex_valid,
    input  lc3b_pkg::ex_mem_t  i_mem,
    input  logic               i_mem_valid,
    input  lc3b_pkg::mem_wb_t  i_wb,
    input  logic               i_wb_valid,
    input  logic               i_imem_wait,
    input  logic               i_dmem_wait,
    output logic [1:0]         o_fwd_a,
    output logic [1:0]         o_fwd_b,
    output logic               o_stall_front,
    output logic               o_bubble_ex,
    output logic               o_stall_all
);

    logic mem_wr, wb_wr;
    logic load_use, cc_busy;

    assign mem_wr = i_mem_valid && i_mem.cw.load_regfile;
    assign wb_wr  = i_wb_valid && i_wb.cw.load_regfile;

    // Younger result in MEM takes precedence
    assign o_fwd_a = (mem_wr && i_mem.dest == i_ex.src1) ? lc3b_pkg::FWD_MEM :
                     (wb_wr && i_wb.dest == i_ex.src1)   ? lc3b_pkg::FWD_WB  :
                                                           lc3b_pkg::FWD_NONE;
    assign o_fwd_b = (mem_wr && i_mem.dest == i_ex.src2) ? lc3b_pkg::FWD_MEM :
                     (wb_wr && i_wb.dest == i_ex.src2)   ? lc3b_pkg::FWD_WB  :
                                                           lc3b_pkg::FWD_NONE;

    // Loaded data reaches EX only from WB
    assign load_use = i_ex_valid && i_ex.cw.mem_read &&
                      (i_ex.dest == i_id_src1 || i_ex.dest == i_id_src2);

    // CC is written at the end of WB, branch compares in ID
    assign cc_busy = (i_ex_valid && i_ex.cw.load_cc) ||
                     (i_mem_valid && i_mem.cw.load_cc) ||
                     (i_wb_valid && i_wb.cw.load_cc);

    assign o_stall_front = load_use || (i_id_is_branch && cc_busy);
    assign o_bubble_ex   = o_stall_front;
    assign o_stall_all   = i_imem_wait || i_dmem_wait;

endmodule : hazard_unit

// File: verilog/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_run,
    input  logic                i_launch,
    input  lc3b_pkg::lc3b_word  i_start_pc,
    input  lc3b_pkg::mem_rsp_t  i_imem,
    input  lc3b_pkg::mem_rsp_t  i_dmem,
    output lc3b_pkg::mem_req_t  o_imem,
    output lc3b_pkg::mem_req_t  o_dmem,
    output logic                o_retire,
    output logic                o_halt_seen
);

    // Fetch
    lc3b_pkg::lc3b_word   pc, instr_q;
    logic                 halt_fetch, fetch_done;
    logic                 imem_hit, imem_wait, if_valid, if_take;
    lc3b_pkg::if_id_t     if_in, id;
    logic                 id_valid;

    // Decode
    lc3b_pkg::ctrl_word_t id_cw;
    lc3b_pkg::lc3b_reg    id_src2;
    lc3b_pkg::lc3b_word   rdata_a, rdata_b, br_target;
    lc3b_pkg::lc3b_nzp    cc, wb_nzp;
    logic                 br_taken, redirect, halt_decode;
    lc3b_pkg::id_ex_t     ex_in, ex;
    logic                 ex_valid;

    // Execute
    logic [1:0]           fwd_a, fwd_b;
    lc3b_pkg::lc3b_word   fwd_a_val, fwd_b_val, alu_b, alu_out;
    lc3b_pkg::ex_mem_t    mem_in, mem;
    logic                 mem_valid;

    // Memory and writeback
    lc3b_pkg::lc3b_word   dmem_rdata_q, mem_rdata;
    logic                 dmem_done, dmem_req, dmem_wait;
    lc3b_pkg::mem_wb_t    wb_in, wb;
    logic                 wb_valid, wb_commit;
    logic                 stall_front, bubble_ex, stall_all;

    /* IF */
    // A fetch returned during a stall is parked in instr_q
    assign o_imem.read  = i_run && !halt_fetch && !fetch_done;
    assign o_imem.write = 1'b0;
    assign o_imem.addr  = pc;
    assign o_imem.wdata = '0;

    assign imem_hit  = o_imem.read && i_imem.resp;
    assign imem_wait = o_imem.read && !i_imem.resp;
    assign if_valid  = imem_hit || fetch_done;
    assign if_take   = !stall_all && !stall_front;

    assign if_in.pc    = pc;
    assign if_in.instr = fetch_done ? instr_q : i_imem.rdata;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc         <= '0;
            halt_fetch <= 1'b0;
            fetch_done <= 1'b0;
        end else if (i_launch) begin
            pc         <= i_start_pc;
            halt_fetch <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            if (halt_decode) halt_fetch <= 1'b1;
            if (if_take) begin
                fetch_done <= 1'b0;
                if (redirect) begin
                    pc <= br_target;
                end else if (if_valid) begin
                    pc <= pc + 16'd2;
                end
            end else if (imem_hit) begin
                fetch_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_hit) instr_q <= i_imem.rdata;
    end

    pipe_stage #(.T(lc3b_pkg::if_id_t)) if_id_inst
    (
        .clk, .i_rst_n,
        .i_hold(stall_all || stall_front), .i_bubble(redirect || halt_decode),
        .i_valid(if_valid), .i_data(if_in),
        .o_valid(id_valid), .o_data(id)
    );

    /* ID */
    cpu_control control_inst (.i_instr(id.instr), .o_cw(id_cw));

    // STR reads its source register through port b
    assign id_src2 = id_cw.mem_write ? id.instr[11:9] : id.instr[2:0];

    regfile regfile_inst
    (
        .clk, .i_rst_n,
        .i_we(wb_commit && wb.cw.load_regfile), .i_dest(wb.dest),
        .i_src_a(id.instr[8:6]), .i_src_b(id_src2), .i_wdata(wb.wb_value),
        .o_rdata_a(rdata_a), .o_rdata_b(rdata_b)
    );

    assign wb_nzp = wb.wb_value[15] ? 3'b100 : (wb.wb_value == '0) ? 3'b010 : 3'b001;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cc <= 3'b010;
        end else if (wb_commit && wb.cw.load_cc) begin
            cc <= wb_nzp;
        end
    end

    assign br_taken    = |(id.instr[11:9] & cc);
    assign br_target   = id.pc + 16'd2 + {{6{id.instr[8]}}, id.instr[8:0], 1'b0};
    assign redirect    = id_valid && id_cw.is_branch && br_taken && if_take;
    assign halt_decode = id_valid && id_cw.is_halt && if_take;

    assign ex_in.cw       = id_cw;
    assign ex_in.dest     = id.instr[11:9];
    assign ex_in.src1     = id.instr[8:6];
    assign ex_in.src2     = id_src2;
    assign ex_in.src1_val = rdata_a;
    assign ex_in.src2_val = rdata_b;
    assign ex_in.imm5     = {{11{id.instr[4]}}, id.instr[4:0]};
    // Word offset, already scaled to bytes
    assign ex_in.offset6  = {{9{id.instr[5]}}, id.instr[5:0], 1'b0};
    assign ex_in.pc       = id.pc;

    hazard_unit hazard_inst
    (
        .i_id_src1(id.instr[8:6]), .i_id_src2(id_src2),
        .i_id_is_branch(id_valid && id_cw.is_branch),
        .i_ex(ex), .i_ex_valid(ex_valid),
        .i_mem(mem), .i_mem_valid(mem_valid),
        .i_wb(wb), .i_wb_valid(wb_valid),
        .i_imem_wait(imem_wait), .i_dmem_wait(dmem_wait),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
        .o_stall_front(stall_front), .o_bubble_ex(bubble_ex), .o_stall_all(stall_all)
    );

    pipe_stage #(.T(lc3b_pkg::id_ex_t)) id_ex_inst
    (
        .clk, .i_rst_n,
        .i_hold(stall_all), .i_bubble(bubble_ex),
        .i_valid(id_valid), .i_data(ex_in),
        .o_valid(ex_valid), .o_data(ex)
    );

    /* EX */
    assign fwd_a_val = (fwd_a == lc3b_pkg::FWD_MEM) ? mem.alu_result :
                       (fwd_a == lc3b_pkg::FWD_WB)  ? wb.wb_value : ex.src1_val;
    assign fwd_b_val = (fwd_b == lc3b_pkg::FWD_MEM) ? mem.alu_result :
                       (fwd_b == lc3b_pkg::FWD_WB)  ? wb.wb_value : ex.src2_val;

    assign alu_b = (ex.cw.mem_read || ex.cw.mem_write) ? ex.offset6 :
                   ex.cw.use_imm                       ? ex.imm5    : fwd_b_val;

    always_comb begin
        case (ex.cw.alu_op)
            lc3b_pkg::alu_and: alu_out = fwd_a_val & alu_b;
            lc3b_pkg::alu_not: alu_out = ~fwd_a_val;
            default:           alu_out = fwd_a_val + alu_b;
        endcase
    end

    assign mem_in.cw         = ex.cw;
    assign mem_in.dest       = ex.dest;
    assign mem_in.alu_result = alu_out;
    assign mem_in.store_data = fwd_b_val;

    pipe_stage #(.T(lc3b_pkg::ex_mem_t)) ex_mem_inst
    (
        .clk, .i_rst_n,
        .i_hold(stall_all), .i_bubble(1'b0),
        .i_valid(ex_valid), .i_data(mem_in),
        .o_valid(mem_valid), .o_data(mem)
    );

    /* MEM */
    // dmem_done stops a finished access from repeating while IF still waits
    assign o_dmem.read  = mem_valid && mem.cw.mem_read && !dmem_done;
    assign o_dmem.write = mem_valid && mem.cw.mem_write && !dmem_done;
    assign o_dmem.addr  = mem.alu_result;
    assign o_dmem.wdata = mem.store_data;

    assign dmem_req  = o_dmem.read || o_dmem.write;
    assign dmem_wait = dmem_req && !i_dmem.resp;
    assign mem_rdata = dmem_done ? dmem_rdata_q : i_dmem.rdata;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dmem_done <= 1'b0;
        end else if (!stall_all) begin
            dmem_done <= 1'b0;
        end else if (dmem_req && i_dmem.resp) begin
            dmem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_dmem.read && i_dmem.resp) dmem_rdata_q <= i_dmem.rdata;
    end

    assign wb_in.cw       = mem.cw;
    assign wb_in.dest     = mem.dest;
    assign wb_in.wb_value = mem.cw.mem_read ? mem_rdata : mem.alu_result;

    pipe_stage #(.T(lc3b_pkg::mem_wb_t)) mem_wb_inst
    (
        .clk, .i_rst_n,
        .i_hold(stall_all), .i_bubble(1'b0),
        .i_valid(mem_valid), .i_data(wb_in),
        .o_valid(wb_valid), .o_data(wb)
    );

    /* WB */
    // Commit once, in the cycle WB actually advances
    assign wb_commit   = wb_valid && !stall_all;
    assign o_retire    = wb_commit;
    assign o_halt_seen = wb_commit && wb.cw.is_halt;

endmodule : cpu_datapath

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
(
    input  logic               clk,
    input  logic               i_rst_n,
    input  lc3b_pkg::apb_req_t i_apb,
    input  lc3b_pkg::mem_rsp_t i_imem,
    input  lc3b_pkg::mem_rsp_t i_dmem,
    output lc3b_pkg::apb_rsp_t o_apb,
    output lc3b_pkg::mem_req_t o_imem,
    output lc3b_pkg::mem_req_t o_dmem
);

    logic               run;
    logic               launch;
    logic               halt_seen;
    logic               retire;
    lc3b_pkg::lc3b_word start_pc;

    cpu_ctrl_regs ctrl_regs_inst
    (
        .clk, .i_rst_n,
        .i_apb, .o_apb,
        .i_halt_seen(halt_seen), .i_retire(retire),
        .o_run(run), .o_start_pc(start_pc), .o_launch(launch)
    );

    cpu_datapath datapath_inst
    (
        .clk, .i_rst_n,
        .i_run(run), .i_launch(launch), .i_start_pc(start_pc),
        .i_imem, .i_dmem, .o_imem, .o_dmem,
        .o_retire(retire), .o_halt_seen(halt_seen)
    );

endmodule : cpu_top

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic o_clk
);

    // 100 ns period
    initial o_clk = 1'b0;
    always #50 o_clk = ~o_clk;

endmodule : tb_clk_gen

// File: test/cpu_top_chk.sv
`timescale 1ns/1ps

module cpu_top_chk
(
    input logic               clk,
    input logic               i_rst_n,
    input logic               i_run,
    input lc3b_pkg::apb_rsp_t i_apb_rsp,
    input lc3b_pkg::mem_req_t i_imem_req,
    input lc3b_pkg::mem_rsp_t i_imem_rsp,
    input lc3b_pkg::mem_req_t i_dmem_req,
    input lc3b_pkg::mem_rsp_t i_dmem_rsp
);

    int fail_count = 0;

    a_dmem_excl: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_dmem_req.read && i_dmem_req.write))
        else begin
            fail_count++;
            $error("Data port requests read and write together");
        end

    // Instruction port is read-only
    a_imem_ro: assert property (@(posedge clk) disable iff (!i_rst_n) !i_imem_req.write)
        else begin
            fail_count++;
            $error("Instruction port issued a write");
        end

    // Requests hold until the response cycle
    a_imem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_imem_req.read && !i_imem_rsp.resp) |=> (i_imem_req.read && $stable(i_imem_req.addr)))
        else begin
            fail_count++;
            $error("Instruction request changed before its response");
        end

    a_dmem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        ((i_dmem_req.read || i_dmem_req.write) && !i_dmem_rsp.resp) |=> $stable(i_dmem_req))
        else begin
            fail_count++;
            $error("Data request changed before its response");
        end

    a_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_run |-> !(i_imem_req.read || i_dmem_req.read || i_dmem_req.write))
        else begin
            fail_count++;
            $error("Memory request issued while stopped");
        end

    a_pready: assert property (@(posedge clk) disable iff (!i_rst_n) i_apb_rsp.pready)
        else begin
            fail_count++;
            $error("APB pready went low");
        end

endmodule : cpu_top_chk

// File: test/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

    // Program A has 19 instructions, program B has 4
    localparam int PROG_LEN   = 23;
    localparam int MAX_CYCLES = 40 * PROG_LEN + 200;

    logic               clk;
    logic               rst_n;
    lc3b_pkg::apb_req_t apb_req;
    lc3b_pkg::apb_rsp_t apb_rsp;
    lc3b_pkg::mem_req_t imem_req, dmem_req;
    lc3b_pkg::mem_rsp_t imem_rsp, dmem_rsp;

    lc3b_pkg::lc3b_word imem [256];
    lc3b_pkg::lc3b_word dmem [256];
    lc3b_pkg::lc3b_word log_addr[$], log_data[$], exp_addr[$], exp_data[$];
    integer seed = 32'h90857d01;
    int     ilat, dlat, cycles, idle_reqs;
    int     value_errors, other_errors;
    logic   idle_watch;

    tb_clk_gen clk_gen_inst (.o_clk(clk));

    cpu_top i_cpu_top
    (
        .clk, .i_rst_n(rst_n), .i_apb(apb_req), .i_imem(imem_rsp), .i_dmem(dmem_rsp),
        .o_apb(apb_rsp), .o_imem(imem_req), .o_dmem(dmem_req)
    );

    bind cpu_top cpu_top_chk cpu_top_chk_inst
    (
        .clk, .i_rst_n, .i_run(run), .i_apb_rsp(o_apb),
        .i_imem_req(o_imem), .i_imem_rsp(i_imem), .i_dmem_req(o_dmem), .i_dmem_rsp(i_dmem)
    );

    function automatic lc3b_pkg::lc3b_word fill_word(input int idx);
        return {idx[7:0], ~idx[7:0]};
    endfunction

    function automatic lc3b_pkg::lc3b_word alu_instr(input logic [3:0] op, input int dr,
                                                     input int sr1, input logic imm, input int v);
        return {op, dr[2:0], sr1[2:0], imm, imm ? v[4:0] : {2'b00, v[2:0]}};
    endfunction

    function automatic lc3b_pkg::lc3b_word mem_instr(input logic [3:0] op, input int r,
                                                     input int base, input int off);
        return {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic lc3b_pkg::lc3b_word br_instr(input logic [2:0] nzp, input int off);
        return {4'b0000, nzp, off[8:0]};
    endfunction

    // Both ports in one process keeps the random draw order fixed
    always @(posedge clk) begin
        lc3b_pkg::mem_req_t ireq;
        lc3b_pkg::mem_req_t dreq;
        ireq = imem_req;
        dreq = dmem_req;
        #1;
        if (imem_rsp.resp) begin
            imem_rsp.resp = 1'b0;
        end else if (ireq.read) begin
            if (ilat == 0) ilat = 1 + $unsigned($random(seed)) % 3;
            ilat--;
            if (ilat == 0) begin
                imem_rsp.resp  = 1'b1;
                imem_rsp.rdata = imem[ireq.addr[8:1]];
            end
        end
        if (dmem_rsp.resp) begin
            dmem_rsp.resp = 1'b0;
        end else if (dreq.read || dreq.write) begin
            if (dlat == 0) dlat = 1 + $unsigned($random(seed)) % 3;
            dlat--;
            if (dlat == 0) begin
                dmem_rsp.resp  = 1'b1;
                dmem_rsp.rdata = dmem[dreq.addr[8:1]];
                if (dreq.write) begin
                    dmem[dreq.addr[8:1]] = dreq.wdata;
                    log_addr.push_back(dreq.addr);
                    log_data.push_back(dreq.wdata);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (idle_watch && (imem_req.read || dmem_req.read || dmem_req.write)) idle_reqs++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input lc3b_pkg::lc3b_word data);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output lc3b_pkg::lc3b_word data,
                            output logic err);
        @(posedge clk);
        #1;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 16'h0};
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic run_program(input lc3b_pkg::lc3b_word start, input int n_retired);
        lc3b_pkg::lc3b_word rd;
        logic err;
        idle_watch = 1'b0;
        apb_write(lc3b_pkg::REG_START_PC, start);
        apb_write(lc3b_pkg::REG_CTRL, 16'h0001);
        rd = '0;
        while (!rd[0]) apb_read(lc3b_pkg::REG_STATUS, rd, err);
        // Halted set and run cleared
        check_value("STATUS", 16'h0001, rd);
        apb_read(lc3b_pkg::REG_RETIRED, rd, err);
        check_value("RETIRED", n_retired[15:0], rd);
        idle_watch = 1'b1;
        repeat (20) @(posedge clk);
        assert (idle_reqs == 0) else begin
            other_errors++;
            $display("Memory requests appeared after halt without a new launch");
        end
        assert (log_addr.size() == exp_addr.size()) else begin
            other_errors++;
            $display("Store log holds %0d stores but %0d were expected",
                     log_addr.size(), exp_addr.size());
        end
        for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            check_value("o_dmem.addr", exp_addr[i], log_addr[i]);
            check_value("o_dmem.wdata", exp_data[i], log_data[i]);
        end
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    initial begin
        lc3b_pkg::lc3b_word rd;
        logic err;
        rst_n      = 1'b0;
        apb_req    = '0;
        imem_rsp   = '0;
        dmem_rsp   = '0;
        idle_watch = 1'b0;
        for (int i = 0; i < 256; i++) begin
            // Unused code space decodes as TRAP
            imem[i] = {8'hF0, i[7:0]};
            dmem[i] = fill_word(i);
        end
        // Program A: ALU chain, stores, load-use, branches, halt
        imem[0]  = alu_instr(lc3b_pkg::op_and, 0, 0, 1'b1, 0);
        imem[1]  = alu_instr(lc3b_pkg::op_add, 1, 0, 1'b1, 5);
        imem[2]  = alu_instr(lc3b_pkg::op_add, 2, 1, 1'b1, -3);
        imem[3]  = alu_instr(lc3b_pkg::op_add, 3, 1, 1'b0, 2);
        imem[4]  = alu_instr(lc3b_pkg::op_and, 4, 3, 1'b1, 6);
        imem[5]  = {4'b1001, 3'd5, 3'd4, 6'h3F};
        imem[6]  = alu_instr(lc3b_pkg::op_add, 6, 0, 1'b1, 8);
        imem[7]  = mem_instr(lc3b_pkg::op_str, 3, 6, 0);
        imem[8]  = mem_instr(lc3b_pkg::op_str, 5, 6, 1);
        imem[9]  = mem_instr(lc3b_pkg::op_str, 4, 6, 2);
        imem[10] = mem_instr(lc3b_pkg::op_ldr, 7, 6, 5);
        imem[11] = alu_instr(lc3b_pkg::op_add, 7, 7, 1'b1, 3);
        imem[12] = mem_instr(lc3b_pkg::op_str, 7, 6, 3);
        imem[13] = br_instr(3'b001, 1);
        imem[14] = mem_instr(lc3b_pkg::op_str, 0, 6, 4);
        imem[15] = alu_instr(lc3b_pkg::op_add, 1, 0, 1'b1, 0);
        imem[16] = br_instr(3'b100, 1);
        imem[17] = mem_instr(lc3b_pkg::op_str, 2, 6, 4);
        imem[18] = 16'hF025;
        // Program B at byte address 0x100
        imem[8'h80] = alu_instr(lc3b_pkg::op_and, 1, 1, 1'b1, 0);
        imem[8'h81] = alu_instr(lc3b_pkg::op_add, 1, 1, 1'b1, -1);
        imem[8'h82] = mem_instr(lc3b_pkg::op_str, 1, 6, 6);
        imem[8'h83] = 16'hF025;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        apb_read(lc3b_pkg::REG_CTRL, rd, err);
        check_value("CTRL", 16'h0, rd);
        apb_read(lc3b_pkg::REG_START_PC, rd, err);
        check_value("START_PC", 16'h0, rd);
        apb_read(lc3b_pkg::REG_STATUS, rd, err);
        check_value("STATUS", 16'h0, rd);
        apb_read(lc3b_pkg::REG_RETIRED, rd, err);
        check_value("RETIRED", 16'h0, rd);
        apb_write(lc3b_pkg::REG_START_PC, 16'h1234);
        apb_read(lc3b_pkg::REG_START_PC, rd, err);
        check_value("START_PC", 16'h1234, rd);
        // Unmapped offset within the 4-bit APB space
        apb_read(4'h2, rd, err);
        check_value("pslverr", 16'h1, {15'd0, err});

        // 7, ~6, 6, loaded word plus 3, then 2 from the fall-through path
        exp_addr = '{16'd8, 16'd10, 16'd12, 16'd14, 16'd16};
        exp_data = '{16'd7, 16'hFFF9, 16'd6, fill_word(9) + 16'd3, 16'd2};
        run_program(16'h0000, 18);

        exp_addr = '{16'd20};
        exp_data = '{16'hFFFF};
        run_program(16'h0100, 4);

        $display("Closing counts: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, i_cpu_top.cpu_top_chk_inst.fail_count);
        if (value_errors + other_errors + i_cpu_top.cpu_top_chk_inst.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_cpu_top

// File: src.f
verilog/lc3b_pkg.sv
verilog/cpu_ctrl_regs.sv
verilog/cpu_control.sv
verilog/regfile.sv
verilog/pipe_stage.sv
verilog/hazard_unit.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
test/tb_clk_gen.sv
test/cpu_top_chk.sv
test/tb_cpu_top.sv
